// ==== cu_pkg.sv ====
package cu_pkg;

	typedef enum logic [2:0]
	{
		st_fetch   = 3'd0,	// Put PC on the address bus, start memory read
		st_pc_inc  = 3'd1,	// Write PC plus 2 back
		st_ir_load = 3'd2,	// MDR into IR
		st_decode  = 3'd3,	// Decoder enable, CEX gating
		st_execute = 3'd4	// One cycle per opcode
	} cycle_state_t;

	typedef enum logic [6:0]
	{
		op_beq = 7'd1,
		op_bne, op_bc, op_bnc, op_bn, op_bge, op_blt,
		op_bra,				// 8
		op_add,				// 9, first ALU opcode
		op_addc, op_sub, op_subc, op_dadd, op_cmp, op_xor,
		op_and, op_or, op_bit, op_bic,
		op_bis,				// 20, last ALU opcode
		op_mov,				// 21
		op_sra = 7'd23,
		op_rrc,				// 24
		op_setcc = 7'd30,
		op_clrcc,			// 31
		op_cex				// 32
	} op_t;

	typedef enum logic [3:0]
	{
		cc_eq = 4'd0, cc_ne, cc_cs, cc_cc, cc_mi, cc_pl, cc_vs, cc_vc,
		cc_hi, cc_ls, cc_ge, cc_lt, cc_gt, cc_le,
		cc_al = 4'd14		// 15 is never true
	} cond_t;

	typedef enum logic [1:0]
	{
		bus_mdr = 2'd0,		// MDR or MAR side
		bus_reg = 2'd1,		// Register file
		bus_ir  = 2'd2,		// Instruction register
		bus_alu = 2'd3		// ALU result
	} bus_src_t;

	typedef struct packed
	{
		logic     valid;	// Transfer happens this cycle
		logic     byte_op;	// Low byte only
		bus_src_t src;
		bus_src_t dst;
	} bus_route_t;

	typedef logic [4:0] reg_num_t;	// 0-7 GPRs, 8-15 constants

	typedef struct packed
	{
		logic [7:0] rest;	// Bits 15:8
		logic [2:0] pri;	// Current priority
		logic       v;
		logic       slp;	// Sleep, set while held at breakpoint
		logic       n;
		logic       z;
		logic       c;
	} psw_t;

	typedef struct packed
	{
		op_t        op;
		logic [2:0] dst;
		logic [2:0] srccon;	// Source register or constant index
		logic       wb;		// Byte operation
		logic       rc;		// Source is a constant
		cond_t      cond;	// CEX condition
		logic [2:0] t_count;
		logic [2:0] f_count;
		logic [4:0] flag_mask;	// SETCC and CLRCC bits
	} decoded_instr_t;

	typedef struct packed
	{
		logic       alu_en;
		logic       decode_en;
		logic       sxt_en;
		logic       mem_read;
		logic       psw_update;	// ALU updates its flags
		logic       s_bus_sxt;	// S bus from sign extender
		logic       psw_from_alu;
		logic [4:0] alu_op;
		bus_route_t dbus;
		bus_route_t abus;
		reg_num_t   dbus_rnum_dst;
		reg_num_t   dbus_rnum_src;
		reg_num_t   alu_rnum_dst;
		reg_num_t   alu_rnum_src;
		reg_num_t   addr_rnum_src;
	} ctrl_word_t;

	typedef struct packed
	{
		logic       start;	// Load the CEX counters
		logic       result;	// Condition held
		logic [2:0] t_count;
		logic [2:0] f_count;
	} cex_load_t;

	typedef struct packed
	{
		logic       set;
		logic       clr;
		logic [4:0] mask;
	} psw_cmd_t;

	localparam reg_num_t   REG_PC     = 5'd7;
	localparam reg_num_t   REG_CONST2 = 5'd10;	// Constant 2 for the PC step
	localparam ctrl_word_t CTRL_IDLE  = '0;
	localparam psw_t       PSW_RESET  = 16'h60e0;	// Priority 7, flags clear
	// Sign bit of the branch offset, wired as a constant into the sign extender
	localparam int         BR_SXT_BIT = 10;

endpackage

// ==== cycle_sequencer.sv ====
`timescale 1ns/10ps

module cycle_sequencer
(
	input  logic                  clock,
	input  logic                  cpucycle_rst,
	input  logic [15:0]           pc,
	input  logic [15:0]           brkpnt,
	input  logic                  issue,		// From CEX gate, valid in decode
	input  logic                  instr_done,	// Execute finished
	output cu_pkg::cycle_state_t  state,
	output logic                  halted		// Fetch blocked by breakpoint
);

	cu_pkg::cycle_state_t state_nxt;

	assign halted = (state == cu_pkg::st_fetch) && (pc == brkpnt);	// Holds for as long as pc matches

	always_comb
	begin
		state_nxt = state;
		case (state)
			cu_pkg::st_fetch:
			begin
				if (!halted)
					state_nxt = cu_pkg::st_pc_inc;	// Else wait in fetch
			end
			cu_pkg::st_pc_inc:
				state_nxt = cu_pkg::st_ir_load;
			cu_pkg::st_ir_load:
				state_nxt = cu_pkg::st_decode;
			cu_pkg::st_decode:
			begin
				if (issue)
					state_nxt = cu_pkg::st_execute;
				else
					state_nxt = cu_pkg::st_fetch;	// Skipped by CEX
			end
			cu_pkg::st_execute:
			begin
				if (instr_done)
					state_nxt = cu_pkg::st_fetch;
			end
			default:
				state_nxt = cu_pkg::st_fetch;	// Recover from unused codes
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			state <= cu_pkg::st_fetch;
		else
			state <= state_nxt;
	end

endmodule

// ==== cex_gate.sv ====
`timescale 1ns/10ps

module cex_gate
(
	input  logic                  clock,
	input  logic                  cpucycle_rst,
	input  cu_pkg::cycle_state_t  state,
	input  cu_pkg::cex_load_t     cex_ld,
	output logic                  issue
);

	logic       active;		// CEX block in progress
	logic       result;		// Stored condition result
	logic [2:0] t_cnt;
	logic [2:0] f_cnt;
	logic [2:0] t_nxt;
	logic [2:0] f_nxt;

	// True slots are consumed first, then false slots
	assign issue = !active
		|| (result && (t_cnt != 3'd0))
		|| (!result && (t_cnt == 3'd0) && (f_cnt != 3'd0));

	always_comb
	begin
		t_nxt = t_cnt;
		f_nxt = f_cnt;
		if (t_cnt != 3'd0)
			t_nxt = t_cnt - 3'd1;
		else if (f_cnt != 3'd0)
			f_nxt = f_cnt - 3'd1;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active <= 1'b0;
			result <= 1'b0;
			t_cnt  <= 3'd0;
			f_cnt  <= 3'd0;
		end
		else if (cex_ld.start)
		begin
			active <= 1'b1;				// Counts apply from the next decode
			result <= cex_ld.result;
			t_cnt  <= cex_ld.t_count;
			f_cnt  <= cex_ld.f_count;
		end
		else if ((state == cu_pkg::st_decode) && active)
		begin
			t_cnt  <= t_nxt;
			f_cnt  <= f_nxt;
			active <= (t_nxt != 3'd0) || (f_nxt != 3'd0);	// Done when both run out
		end
	end

endmodule

// ==== cond_eval.sv ====
`timescale 1ns/10ps

module cond_eval
(
	input  cu_pkg::cond_t  cond,
	input  cu_pkg::psw_t   flags,
	output logic           taken
);

	logic n_eq_v;

	assign n_eq_v = (flags.n == flags.v);	// Signed compare result

	always_comb
	begin
		case (cond)
			cu_pkg::cc_eq: taken = flags.z;
			cu_pkg::cc_ne: taken = !flags.z;
			cu_pkg::cc_cs: taken = flags.c;
			cu_pkg::cc_cc: taken = !flags.c;
			cu_pkg::cc_mi: taken = flags.n;
			cu_pkg::cc_pl: taken = !flags.n;
			cu_pkg::cc_vs: taken = flags.v;
			cu_pkg::cc_vc: taken = !flags.v;
			cu_pkg::cc_hi: taken = flags.c && !flags.z;	// Unsigned higher
			cu_pkg::cc_ls: taken = !flags.c || flags.z;
			cu_pkg::cc_ge: taken = n_eq_v;
			cu_pkg::cc_lt: taken = !n_eq_v;
			cu_pkg::cc_gt: taken = !flags.z && n_eq_v;
			cu_pkg::cc_le: taken = flags.z || !n_eq_v;
			cu_pkg::cc_al: taken = 1'b1;
			default:       taken = 1'b0;	// Code 15
		endcase
	end

endmodule

// ==== exec_control.sv ====
`timescale 1ns/10ps

module exec_control
(
	input  logic                    clock,
	input  logic                    cpucycle_rst,
	input  cu_pkg::cycle_state_t    state,
	input  logic                    halted,
	input  logic                    issue,
	input  cu_pkg::decoded_instr_t  instr,
	input  cu_pkg::psw_t            psw_in,
	output cu_pkg::ctrl_word_t      ctrl,
	output logic                    instr_done,
	output cu_pkg::cex_load_t       cex_ld,
	output cu_pkg::psw_cmd_t        psw_cmd
);

	cu_pkg::ctrl_word_t word_nxt;
	cu_pkg::cond_t      br_cond;
	logic               taken;
	logic [3:0]         alu_base;	// Opcode offset into the ALU table
	logic               is_exec;

	assign is_exec    = (state == cu_pkg::st_execute);
	assign instr_done = is_exec;	// Every execute step is one cycle

	always_comb
	begin
		case (instr.op)
			cu_pkg::op_beq: br_cond = cu_pkg::cc_eq;
			cu_pkg::op_bne: br_cond = cu_pkg::cc_ne;
			cu_pkg::op_bc:  br_cond = cu_pkg::cc_cs;
			cu_pkg::op_bnc: br_cond = cu_pkg::cc_cc;
			cu_pkg::op_bn:  br_cond = cu_pkg::cc_mi;
			cu_pkg::op_bge: br_cond = cu_pkg::cc_ge;
			cu_pkg::op_blt: br_cond = cu_pkg::cc_lt;
			cu_pkg::op_bra: br_cond = cu_pkg::cc_al;
			default:        br_cond = instr.cond;	// CEX condition field
		endcase
	end

	cond_eval u_cond_eval
	(
		.cond  (br_cond),
		.flags (psw_in),
		.taken (taken)
	);

	// Shifts skip opcode 22 and the offset wraps within four bits
	assign alu_base = 4'(instr.op) -
		(((instr.op == cu_pkg::op_sra) || (instr.op == cu_pkg::op_rrc)) ? 4'd11 : 4'd9);

	always_comb
	begin
		word_nxt = cu_pkg::CTRL_IDLE;
		case (state)
			cu_pkg::st_fetch:
			begin
				if (!halted)
				begin
					word_nxt.alu_rnum_dst  = cu_pkg::REG_PC;
					word_nxt.alu_rnum_src  = cu_pkg::REG_CONST2;	// Preset PC plus 2
					word_nxt.alu_op        = 5'd0;				// Add
					word_nxt.dbus_rnum_dst = cu_pkg::REG_PC;
					word_nxt.addr_rnum_src = cu_pkg::REG_PC;
					// PC to MAR
					word_nxt.abus          = '{1'b1, 1'b0, cu_pkg::bus_reg, cu_pkg::bus_mdr};
					word_nxt.mem_read      = 1'b1;
				end
			end
			cu_pkg::st_pc_inc:
			begin
				word_nxt.alu_en = 1'b1;
				word_nxt.dbus   = '{1'b1, 1'b0, cu_pkg::bus_alu, cu_pkg::bus_reg};	// Write PC back
			end
			cu_pkg::st_ir_load:
				word_nxt.dbus = '{1'b1, 1'b0, cu_pkg::bus_mdr, cu_pkg::bus_ir};
			cu_pkg::st_decode:
				word_nxt.decode_en = issue;	// No decode for a skipped instruction
			cu_pkg::st_execute:
			begin
				case (instr.op) inside
					[cu_pkg::op_beq:cu_pkg::op_bra]:
					begin
						if (taken)
						begin
							word_nxt.sxt_en        = 1'b1;	// Offset from sign extender
							word_nxt.s_bus_sxt     = 1'b1;
							word_nxt.alu_en        = 1'b1;
							word_nxt.alu_op        = 5'd0;	// PC plus offset
							word_nxt.alu_rnum_dst  = cu_pkg::REG_PC;
							word_nxt.dbus_rnum_dst = cu_pkg::REG_PC;
							word_nxt.dbus = '{1'b1, 1'b0, cu_pkg::bus_alu, cu_pkg::bus_reg};
						end
					end
					[cu_pkg::op_add:cu_pkg::op_bis], cu_pkg::op_sra, cu_pkg::op_rrc:
					begin
						word_nxt.alu_op        = {alu_base, instr.wb};	// Word and byte pairs
						word_nxt.alu_rnum_dst  = {2'b00, instr.dst};
						word_nxt.dbus_rnum_dst = {2'b00, instr.dst};
						word_nxt.alu_rnum_src  = {1'b0, instr.rc, instr.srccon};	// Constants at 8-15
						word_nxt.psw_update    = 1'b1;
						word_nxt.psw_from_alu  = 1'b1;
						word_nxt.alu_en        = 1'b1;
						word_nxt.dbus = '{1'b1, instr.wb, cu_pkg::bus_alu, cu_pkg::bus_reg};
					end
					cu_pkg::op_mov:
					begin
						word_nxt.dbus_rnum_src = {2'b00, instr.srccon};
						word_nxt.dbus_rnum_dst = {2'b00, instr.dst};
						word_nxt.dbus = '{1'b1, instr.wb, cu_pkg::bus_reg, cu_pkg::bus_reg};
					end
					default:
						word_nxt = cu_pkg::CTRL_IDLE;	// PSW and CEX ops use side outputs
				endcase
			end
			default:
				word_nxt = cu_pkg::CTRL_IDLE;
		endcase
	end

	always_comb
	begin
		cex_ld.start   = is_exec && (instr.op == cu_pkg::op_cex);
		cex_ld.result  = taken;			// Condition from instr.cond here
		cex_ld.t_count = instr.t_count;
		cex_ld.f_count = instr.f_count;
		psw_cmd.set    = is_exec && (instr.op == cu_pkg::op_setcc);
		psw_cmd.clr    = is_exec && (instr.op == cu_pkg::op_clrcc);
		psw_cmd.mask   = instr.flag_mask;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			ctrl <= cu_pkg::CTRL_IDLE;
		else
			ctrl <= word_nxt;	// One cycle behind state
	end

endmodule

// ==== psw_stage.sv ====
`timescale 1ns/10ps

module psw_stage
(
	input  logic               clock,
	input  logic               cpucycle_rst,
	input  cu_pkg::psw_t       psw_in,
	input  logic               halted,
	input  cu_pkg::psw_cmd_t   psw_cmd,
	output cu_pkg::psw_t       psw_out
);

	logic [4:0]   flags;	// V, SLP, N, Z, C
	cu_pkg::psw_t psw_nxt;

	always_comb
	begin
		flags = {psw_in.v, psw_in.slp, psw_in.n, psw_in.z, psw_in.c};
		if (psw_cmd.set)
			flags = flags | psw_cmd.mask;	// SETCC
		if (psw_cmd.clr)
			flags = flags & ~psw_cmd.mask;	// CLRCC
		psw_nxt = psw_in;					// Priority and upper bits pass through
		{psw_nxt.v, psw_nxt.slp, psw_nxt.n, psw_nxt.z, psw_nxt.c} = flags;
		psw_nxt.slp = halted;				// Sleep while held at breakpoint
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw_out <= cu_pkg::PSW_RESET;
		else
			psw_out <= psw_nxt;
	end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/10ps

module control_unit
(
	input  logic                    clock,
	input  logic                    cpucycle_rst,
	input  logic [15:0]             pc,
	input  logic [15:0]             brkpnt,
	input  cu_pkg::decoded_instr_t  instr,
	input  cu_pkg::psw_t            psw_in,
	output cu_pkg::ctrl_word_t      ctrl,
	output cu_pkg::psw_t            psw_out
);

	cu_pkg::cycle_state_t state;
	logic                 halted;
	logic                 issue;		// CEX decision for the decoded instruction
	logic                 instr_done;
	cu_pkg::cex_load_t    cex_ld;
	cu_pkg::psw_cmd_t     psw_cmd;

	cycle_sequencer u_cycle_sequencer
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.pc           (pc),
		.brkpnt       (brkpnt),
		.issue        (issue),
		.instr_done   (instr_done),
		.state        (state),
		.halted       (halted)
	);

	cex_gate u_cex_gate
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.state        (state),
		.cex_ld       (cex_ld),
		.issue        (issue)
	);

	exec_control u_exec_control
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.state        (state),
		.halted       (halted),
		.issue        (issue),
		.instr        (instr),
		.psw_in       (psw_in),
		.ctrl         (ctrl),
		.instr_done   (instr_done),
		.cex_ld       (cex_ld),
		.psw_cmd      (psw_cmd)
	);

	psw_stage u_psw_stage
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.psw_in       (psw_in),
		.halted       (halted),
		.psw_cmd      (psw_cmd),
		.psw_out      (psw_out)
	);

endmodule

// ==== tb_control_unit.sv ====
`timescale 1ns/10ps

module tb_control_unit;

	localparam int NUM_INSTR   = 400;
	localparam int CYCLE_LIMIT = NUM_INSTR * 13 + 50;	// Five cycles and an 8-cycle hold each

	logic                   clock;
	logic                   cpucycle_rst;
	logic [15:0]            pc;
	logic [15:0]            brkpnt;
	cu_pkg::decoded_instr_t instr;
	cu_pkg::psw_t           psw_in;
	cu_pkg::ctrl_word_t     ctrl;
	cu_pkg::psw_t           psw_out;

	integer               seed;
	int                   cycle_count;
	int                   instr_count;	// Executed or skipped instructions
	int                   bp_left;		// Cycles left in a breakpoint stretch
	cu_pkg::cycle_state_t m_state;		// Model of the instruction cycle
	logic                 m_active;		// Model CEX block
	logic                 m_result;
	logic [2:0]           m_t;
	logic [2:0]           m_f;
	cu_pkg::ctrl_word_t   exp_ctrl;
	logic [15:0]          exp_psw;
	string                step_name;

	control_unit u_dut
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.pc           (pc),
		.brkpnt       (brkpnt),
		.instr        (instr),
		.psw_in       (psw_in),
		.ctrl         (ctrl),
		.psw_out      (psw_out)
	);

	always #2 clock = ~clock;	// 4 ns period

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: %0d instructions not done after %0d cycles",
				NUM_INSTR, CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic expect_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act)
		begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "Mismatch at %0t", $time);
		end
	endtask

	// Condition table over C=bit 0, Z=bit 1, N=bit 2, V=bit 4
	function automatic logic cond_holds(input logic [3:0] code, input logic [15:0] p);
		logic nv;
		nv = p[2] ^ p[4];	// N differs from V
		case (code)
			4'd0:    cond_holds = p[1];
			4'd1:    cond_holds = !p[1];
			4'd2:    cond_holds = p[0];
			4'd3:    cond_holds = !p[0];
			4'd4:    cond_holds = p[2];
			4'd5:    cond_holds = !p[2];
			4'd6:    cond_holds = p[4];
			4'd7:    cond_holds = !p[4];
			4'd8:    cond_holds = p[0] & !p[1];
			4'd9:    cond_holds = !p[0] | p[1];
			4'd10:   cond_holds = !nv;
			4'd11:   cond_holds = nv;
			4'd12:   cond_holds = !p[1] & !nv;
			4'd13:   cond_holds = p[1] | nv;
			4'd14:   cond_holds = 1'b1;
			default: cond_holds = 1'b0;	// Code 15 never holds
		endcase
	endfunction

	function automatic logic [3:0] branch_code(input logic [6:0] opv);
		case (opv)
			7'd6:    branch_code = 4'd10;	// BGE
			7'd7:    branch_code = 4'd11;	// BLT
			7'd8:    branch_code = 4'd14;	// BRA
			default: branch_code = opv[3:0] - 4'd1;	// BEQ to BN map onto eq..mi
		endcase
	endfunction

	function automatic cu_pkg::ctrl_word_t exec_word(input cu_pkg::decoded_instr_t d,
		input logic [15:0] p);
		cu_pkg::ctrl_word_t w;
		logic [6:0]         opv;
		logic [6:0]         idx;
		w   = '0;
		opv = d.op;
		idx = (opv <= 7'd20) ? opv - 7'd9 : opv - 7'd11;	// SRA and RRC follow BIS in the table
		if ((opv >= 7'd1) && (opv <= 7'd8))
		begin
			if (cond_holds(branch_code(opv), p))
			begin
				w.sxt_en        = 1'b1;
				w.s_bus_sxt     = 1'b1;
				w.alu_en        = 1'b1;
				w.alu_rnum_dst  = 5'd7;	// PC plus offset
				w.dbus_rnum_dst = 5'd7;
				w.dbus.valid    = 1'b1;
				w.dbus.src      = cu_pkg::bus_alu;
				w.dbus.dst      = cu_pkg::bus_reg;
			end
		end
		else if (((opv >= 7'd9) && (opv <= 7'd20)) || (opv == 7'd23) || (opv == 7'd24))
		begin
			w.alu_op        = {idx[3:0], d.wb};
			w.alu_rnum_dst  = {2'b00, d.dst};
			w.dbus_rnum_dst = {2'b00, d.dst};
			w.alu_rnum_src  = {2'b00, d.srccon} + (d.rc ? 5'd8 : 5'd0);	// Constant bank
			w.psw_update    = 1'b1;
			w.psw_from_alu  = 1'b1;
			w.alu_en        = 1'b1;
			w.dbus.valid    = 1'b1;
			w.dbus.byte_op  = d.wb;
			w.dbus.src      = cu_pkg::bus_alu;
			w.dbus.dst      = cu_pkg::bus_reg;
		end
		else if (opv == 7'd21)
		begin
			w.dbus_rnum_src = {2'b00, d.srccon};	// MOV
			w.dbus_rnum_dst = {2'b00, d.dst};
			w.dbus.valid    = 1'b1;
			w.dbus.byte_op  = d.wb;
			w.dbus.src      = cu_pkg::bus_reg;
			w.dbus.dst      = cu_pkg::bus_reg;
		end
		exec_word = w;
	endfunction

	// Predict the registered outputs from the inputs seen at this edge
	task automatic step_model();
		logic                 halted;
		logic                 issue;
		logic [6:0]           opv;
		logic [15:0]          p;
		logic [2:0]           t_new;
		logic [2:0]           f_new;
		cu_pkg::cycle_state_t next_state;
		halted     = (m_state == cu_pkg::st_fetch) && (pc == brkpnt);
		issue      = !m_active || (m_result ? (m_t != 3'd0) : ((m_t == 3'd0) && (m_f != 3'd0)));
		opv        = instr.op;
		p          = psw_in;
		exp_ctrl   = '0;
		next_state = cu_pkg::st_fetch;
		if (cpucycle_rst)
		begin
			m_state   = cu_pkg::st_fetch;
			m_active  = 1'b0;
			m_result  = 1'b0;
			m_t       = 3'd0;
			m_f       = 3'd0;
			exp_psw   = cu_pkg::PSW_RESET;
			step_name = "reset";
		end
		else
		begin
			case (m_state)
				cu_pkg::st_fetch:
				begin
					step_name = halted ? "breakpoint" : "fetch";
					next_state = halted ? cu_pkg::st_fetch : cu_pkg::st_pc_inc;
					if (!halted)
					begin
						exp_ctrl.alu_rnum_dst  = 5'd7;
						exp_ctrl.alu_rnum_src  = 5'd10;	// Constant 2
						exp_ctrl.dbus_rnum_dst = 5'd7;
						exp_ctrl.addr_rnum_src = 5'd7;
						exp_ctrl.abus.valid    = 1'b1;
						exp_ctrl.abus.src      = cu_pkg::bus_reg;
						exp_ctrl.abus.dst      = cu_pkg::bus_mdr;
						exp_ctrl.mem_read      = 1'b1;
					end
				end
				cu_pkg::st_pc_inc:
				begin
					step_name = "pc_inc";
					next_state = cu_pkg::st_ir_load;
					exp_ctrl.alu_en     = 1'b1;
					exp_ctrl.dbus.valid = 1'b1;
					exp_ctrl.dbus.src   = cu_pkg::bus_alu;
					exp_ctrl.dbus.dst   = cu_pkg::bus_reg;
				end
				cu_pkg::st_ir_load:
				begin
					step_name = "ir_load";
					next_state = cu_pkg::st_decode;
					exp_ctrl.dbus.valid = 1'b1;
					exp_ctrl.dbus.src   = cu_pkg::bus_mdr;
					exp_ctrl.dbus.dst   = cu_pkg::bus_ir;
				end
				cu_pkg::st_decode:
				begin
					step_name = issue ? "decode" : "decode skip";
					next_state = issue ? cu_pkg::st_execute : cu_pkg::st_fetch;
					exp_ctrl.decode_en = issue;
					if (!issue)
						instr_count++;
				end
				default:
				begin
					step_name = $sformatf("execute op %0d", opv);
					exp_ctrl = exec_word(instr, psw_in);
					if (opv == 7'd30)
						p[4:0] = p[4:0] | instr.flag_mask;	// SETCC
					if (opv == 7'd31)
						p[4:0] = p[4:0] & ~instr.flag_mask;	// CLRCC
					instr_count++;
				end
			endcase
			if ((m_state == cu_pkg::st_execute) && (opv == 7'd32))
			begin
				m_active = 1'b1;	// CEX loads its counts
				m_result = cond_holds(instr.cond, psw_in);
				m_t      = instr.t_count;
				m_f      = instr.f_count;
			end
			else if ((m_state == cu_pkg::st_decode) && m_active)
			begin
				t_new    = (m_t != 3'd0) ? m_t - 3'd1 : m_t;
				f_new    = ((m_t == 3'd0) && (m_f != 3'd0)) ? m_f - 3'd1 : m_f;
				m_t      = t_new;
				m_f      = f_new;
				m_active = (t_new != 3'd0) || (f_new != 3'd0);
			end
			p[3]    = halted;	// Sleep bit
			exp_psw = p;
			m_state = next_state;
		end
	endtask

	task automatic drive_inputs();
		logic [31:0]            r_op;
		logic [31:0]            r_fld;
		logic [31:0]            r_psw;
		logic [31:0]            r_bp;
		logic [6:0]             opv;
		cu_pkg::decoded_instr_t d;
		r_op  = $random(seed);
		r_fld = $random(seed);
		r_psw = $random(seed);
		r_bp  = $random(seed);
		if (r_op[4:0] <= 5'd20)
			opv = {2'b00, r_op[4:0]} + 7'd1;	// Branches, ALU ops, MOV
		else
		begin
			case (r_op[4:0])
				5'd21:             opv = 7'd23;
				5'd22:             opv = 7'd24;
				5'd23:             opv = 7'd30;
				5'd24:             opv = 7'd31;
				5'd25, 5'd26, 5'd27: opv = 7'd32;	// CEX more often
				default:           opv = r_op[14:8];	// Mostly unused codes
			endcase
		end
		d      = cu_pkg::decoded_instr_t'(r_fld[29:0]);
		d.op   = cu_pkg::op_t'(opv);
		instr  <= d;
		psw_in <= cu_pkg::psw_t'(r_psw[15:0]);
		if ((bp_left == 0) && (r_bp[3:0] == 4'd0))
			bp_left = 1 + int'(r_bp[6:4]);	// 1 to 8 cycles
		if (bp_left != 0)
		begin
			pc <= brkpnt;
			bp_left = bp_left - 1;
		end
		else
			pc <= brkpnt ^ (r_bp[31:16] | 16'h0001);	// Never equal to brkpnt
	endtask

	initial
	begin
		seed         = 79455;
		clock        = 1'b0;
		cpucycle_rst = 1'b1;
		pc           = 16'h0000;
		brkpnt       = 16'h3a5c;
		instr        = '0;
		psw_in       = '0;
		cycle_count  = 0;
		instr_count  = 0;
		bp_left      = 0;
		m_state      = cu_pkg::st_fetch;
		m_active     = 1'b0;
		m_result     = 1'b0;
		m_t          = 3'd0;
		m_f          = 3'd0;
		for (int n = 1; instr_count < NUM_INSTR; n++)
		begin
			@(posedge clock);
			step_model();
			drive_inputs();
			if (n >= 3)
				cpucycle_rst <= 1'b0;	// Released after the third edge
			@(negedge clock);
			expect_equal({"ctrl ", step_name}, 64'(exp_ctrl), 64'(ctrl));
			expect_equal({"psw ", step_name}, 64'(exp_psw), 64'(psw_out));
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
cu_pkg.sv
cycle_sequencer.sv
cex_gate.sv
cond_eval.sv
exec_control.sv
psw_stage.sv
control_unit.sv
tb_control_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the control unit testbench with Verilator, run it, and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_control_unit -f flist.f \
	&& ./obj_dir/Vtb_control_unit > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
exit 0
